// File: verilog/operands_pkg.sv
// Shared constants, opcode and state enums, instruction, writeback and operand bundle structs
package operands_pkg;

    localparam int XLEN       = 32;
    localparam int THREAD_CNT = 4;
    localparam int WARP_CNT   = 8;
    localparam int NUM_REGS   = 32;
    localparam int NR_BITS    = 5;
    localparam int WID_BITS   = 3;
    localparam int UUID_BITS  = 8;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        MUL,
        BRANCH,
        LOAD,
        STORE
    } op_type_e;

    typedef enum logic [1:0] {
        IDLE,
        FETCH_RS1,
        FETCH_RS2,
        FETCH_RS3
    } collector_state_e;

    typedef logic [THREAD_CNT-1:0][XLEN-1:0] lane_data_t;

    // Instruction as it leaves the scoreboard
    typedef struct packed {
        logic [UUID_BITS-1:0]  uuid;
        logic [WID_BITS-1:0]   wid;
        logic [THREAD_CNT-1:0] tmask;
        logic [XLEN-1:0]       pc;
        op_type_e              op_type;
        logic                  use_imm;
        logic [XLEN-1:0]       imm;
        logic                  wb;
        logic [NR_BITS-1:0]    rd;
        logic [NR_BITS-1:0]    rs1;
        logic [NR_BITS-1:0]    rs2;
        logic [NR_BITS-1:0]    rs3;
    } issue_t;

    typedef struct packed {
        logic [WID_BITS-1:0]   wid;
        logic [THREAD_CNT-1:0] tmask;
        logic [NR_BITS-1:0]    rd;
        lane_data_t            data;
    } writeback_t;

    // Source register numbers are replaced by the collected lane vectors
    typedef struct packed {
        logic [UUID_BITS-1:0]  uuid;
        logic [WID_BITS-1:0]   wid;
        logic [THREAD_CNT-1:0] tmask;
        logic [XLEN-1:0]       pc;
        op_type_e              op_type;
        logic                  use_imm;
        logic [XLEN-1:0]       imm;
        logic                  wb;
        logic [NR_BITS-1:0]    rd;
        lane_data_t            rs1_data;
        lane_data_t            rs2_data;
        lane_data_t            rs3_data;
    } operands_t;

endpackage

// File: verilog/gpr_bank.sv
// Dual-port register bank for one thread lane with synchronous read
`timescale 1ns/1ps

module gpr_bank import operands_pkg::*; #(
    parameter int DEPTH = 64
) (
    input  logic                     clk,
    input  logic                     write,
    input  logic [$clog2(DEPTH)-1:0] waddr,
    input  logic [XLEN-1:0]          wdata,
    input  logic [$clog2(DEPTH)-1:0] raddr,
    output logic [XLEN-1:0]          rdata
);

    logic [XLEN-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (write) begin
            mem[waddr] <= wdata;
        end
    end

    // A read in the same cycle as a write to that address sees the old word
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

// File: verilog/elastic_buffer.sv
// Valid/ready FIFO of one or two entries with a registered output stage
`timescale 1ns/1ps

module elastic_buffer #(
    parameter int DATA_W = 32,
    parameter int DEPTH  = 2
) (
    input  logic              clk,
    input  logic              reset,
    input  logic              valid_in,
    output logic              ready_in,
    input  logic [DATA_W-1:0] data_in,
    output logic [DATA_W-1:0] data_out,
    output logic              valid_out,
    input  logic              ready_out
);

    logic [DATA_W-1:0] skid_data;
    logic              skid_valid;
    logic              push;
    logic              pop;
    logic              head_load;

    // With one entry only the head register holds data
    assign ready_in  = (DEPTH == 1) ? !valid_out : !skid_valid;
    assign push      = valid_in && ready_in;
    assign pop       = valid_out && ready_out;
    assign head_load = !valid_out || pop;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_out  <= 1'b0;
            skid_valid <= 1'b0;
        end else if (head_load) begin
            if (skid_valid) begin
                valid_out  <= 1'b1;
                skid_valid <= push;
            end else begin
                valid_out <= push;
            end
        end else if (push) begin
            skid_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (head_load) begin
            data_out <= skid_valid ? skid_data : data_in;
        end
        if (push && (skid_valid || !head_load)) begin
            skid_data <= data_in;
        end
    end

endmodule

// File: verilog/operand_collector.sv
// Issue slot: fetch FSM, per-lane register banks, staging buffer and output buffer
`timescale 1ns/1ps

module operand_collector import operands_pkg::*; #(
    parameter int ISSUE_CNT = 2
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       issue_valid,
    output logic       issue_ready,
    input  issue_t     issue_data,
    input  logic       wb_valid,
    input  writeback_t wb_data,
    output logic       out_valid,
    input  logic       out_ready,
    output operands_t  out_data
);

    localparam int WARPS_PER_SLICE = WARP_CNT / ISSUE_CNT;
    localparam int WIS_BITS        = $clog2(WARPS_PER_SLICE);
    localparam int BANK_DEPTH      = NUM_REGS * WARPS_PER_SLICE;
    localparam int ADDR_W          = WIS_BITS + NR_BITS;

    collector_state_e state, state_n;
    logic             data_ready, data_ready_n;
    lane_data_t       rs1_data, rs1_data_n;
    lane_data_t       rs2_data, rs2_data_n;
    lane_data_t       rs3_data, rs3_data_n;
    lane_data_t       gpr_rdata;

    logic [WID_BITS-1:0] rd_wid;
    logic [NR_BITS-1:0]  rd_rid;

    issue_t    stg_data;
    logic      stg_valid;
    logic      stg_ready;
    logic      issue_fire;
    logic      stg_pop;
    logic      out_in_valid;
    logic      out_in_ready;
    operands_t bundle;

    // Bank rows are grouped by warp index within the slice
    function automatic logic [ADDR_W-1:0] bank_addr(input logic [WID_BITS-1:0] wid,
                                                    input logic [NR_BITS-1:0] rid);
        return {wid[WIS_BITS-1:0], rid};
    endfunction

    assign issue_fire   = issue_valid && issue_ready;
    assign out_in_valid = stg_valid && data_ready;
    assign stg_ready    = data_ready && out_in_ready;
    assign stg_pop      = stg_valid && stg_ready;

    // Sources are decoded on the issue handshake, then read one per cycle
    always_comb begin
        state_n      = state;
        data_ready_n = data_ready;
        rs1_data_n   = rs1_data;
        rs2_data_n   = rs2_data;
        rs3_data_n   = rs3_data;
        rd_wid       = stg_data.wid;
        rd_rid       = '0;
        case (state)
            IDLE: begin
                rd_wid = issue_data.wid;
                if (stg_pop) begin
                    data_ready_n = 1'b0;
                end
                if (issue_fire) begin
                    rs1_data_n = '0;
                    rs2_data_n = '0;
                    rs3_data_n = '0;
                    if (issue_data.rs1 != '0) begin
                        rd_rid  = issue_data.rs1;
                        state_n = FETCH_RS1;
                    end else if (issue_data.rs2 != '0) begin
                        rd_rid  = issue_data.rs2;
                        state_n = FETCH_RS2;
                    end else if (issue_data.rs3 != '0) begin
                        rd_rid  = issue_data.rs3;
                        state_n = FETCH_RS3;
                    end else begin
                        data_ready_n = 1'b1;
                    end
                end
            end
            FETCH_RS1: begin
                rs1_data_n = gpr_rdata;
                if (stg_data.rs2 != '0) begin
                    rd_rid  = stg_data.rs2;
                    state_n = FETCH_RS2;
                end else if (stg_data.rs3 != '0) begin
                    rd_rid  = stg_data.rs3;
                    state_n = FETCH_RS3;
                end else begin
                    data_ready_n = 1'b1;
                    state_n      = IDLE;
                end
            end
            FETCH_RS2: begin
                rs2_data_n = gpr_rdata;
                if (stg_data.rs3 != '0) begin
                    rd_rid  = stg_data.rs3;
                    state_n = FETCH_RS3;
                end else begin
                    data_ready_n = 1'b1;
                    state_n      = IDLE;
                end
            end
            FETCH_RS3: begin
                rs3_data_n   = gpr_rdata;
                data_ready_n = 1'b1;
                state_n      = IDLE;
            end
            default: state_n = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            state      <= IDLE;
            data_ready <= 1'b0;
        end else begin
            state      <= state_n;
            data_ready <= data_ready_n;
        end
    end

    always_ff @(posedge clk) begin
        rs1_data <= rs1_data_n;
        rs2_data <= rs2_data_n;
        rs3_data <= rs3_data_n;
    end

    for (genvar j = 0; j < THREAD_CNT; j++) begin : g_lane
        gpr_bank #(
            .DEPTH (BANK_DEPTH)
        ) bank (
            .clk   (clk),
            .write (wb_valid && wb_data.tmask[j]),
            .waddr (bank_addr(wb_data.wid, wb_data.rd)),
            .wdata (wb_data.data[j]),
            .raddr (bank_addr(rd_wid, rd_rid)),
            .rdata (gpr_rdata[j])
        );
    end

    elastic_buffer #(
        .DATA_W ($bits(issue_t)),
        .DEPTH  (1)
    ) stg_buf (
        .clk       (clk),
        .reset     (reset || flush),
        .valid_in  (issue_valid),
        .ready_in  (issue_ready),
        .data_in   (issue_data),
        .data_out  (stg_data),
        .valid_out (stg_valid),
        .ready_out (stg_ready)
    );

    always_comb begin
        bundle.uuid     = stg_data.uuid;
        bundle.wid      = stg_data.wid;
        bundle.tmask    = stg_data.tmask;
        bundle.pc       = stg_data.pc;
        bundle.op_type  = stg_data.op_type;
        bundle.use_imm  = stg_data.use_imm;
        bundle.imm      = stg_data.imm;
        bundle.wb       = stg_data.wb;
        bundle.rd       = stg_data.rd;
        bundle.rs1_data = rs1_data;
        bundle.rs2_data = rs2_data;
        bundle.rs3_data = rs3_data;
    end

    elastic_buffer #(
        .DATA_W ($bits(operands_t)),
        .DEPTH  (2)
    ) out_buf (
        .clk       (clk),
        .reset     (reset || flush),
        .valid_in  (out_in_valid),
        .ready_in  (out_in_ready),
        .data_in   (bundle),
        .data_out  (out_data),
        .valid_out (out_valid),
        .ready_out (out_ready)
    );

endmodule

// File: verilog/warp_router.sv
// Warp-to-slice steering of issued instructions and writebacks
`timescale 1ns/1ps

module warp_router import operands_pkg::*; #(
    parameter int ISSUE_CNT = 2
) (
    input  logic                 issue_valid,
    output logic                 issue_ready,
    input  issue_t               issue_data,
    input  logic                 wb_valid,
    input  writeback_t           wb_data,
    output logic [ISSUE_CNT-1:0] slice_issue_valid,
    input  logic [ISSUE_CNT-1:0] slice_ready,
    output issue_t               slice_issue_data,
    output logic [ISSUE_CNT-1:0] slice_wb_valid,
    output writeback_t           slice_wb_data
);

    localparam int SEL_BITS = (ISSUE_CNT > 1) ? $clog2(ISSUE_CNT) : 1;

    logic [SEL_BITS-1:0] issue_sel;
    logic [SEL_BITS-1:0] wb_sel;

    // A warp lives in slice wid mod ISSUE_CNT
    assign issue_sel   = SEL_BITS'(issue_data.wid % ISSUE_CNT);
    assign wb_sel      = SEL_BITS'(wb_data.wid % ISSUE_CNT);
    assign issue_ready = slice_ready[issue_sel];

    always_comb begin
        for (int i = 0; i < ISSUE_CNT; i++) begin
            slice_issue_valid[i] = issue_valid && (int'(issue_sel) == i);
            slice_wb_valid[i]    = wb_valid && (int'(wb_sel) == i);
        end
    end

    // Inside a slice the warp is addressed by its index there
    always_comb begin
        slice_issue_data     = issue_data;
        slice_issue_data.wid = WID_BITS'(issue_data.wid / ISSUE_CNT);
        slice_wb_data        = wb_data;
        slice_wb_data.wid    = WID_BITS'(wb_data.wid / ISSUE_CNT);
    end

endmodule

// File: verilog/exec_arbiter.sv
// Round-robin merge of collector outputs into a registered execution port
`timescale 1ns/1ps

module exec_arbiter import operands_pkg::*; #(
    parameter int ISSUE_CNT = 2
) (
    input  logic                      clk,
    input  logic                      reset,
    input  logic [ISSUE_CNT-1:0]      col_valid,
    output logic [ISSUE_CNT-1:0]      col_ready,
    input  operands_t [ISSUE_CNT-1:0] col_data,
    output logic                      exe_valid,
    input  logic                      exe_ready,
    output operands_t                 exe_data
);

    localparam int SEL_BITS = (ISSUE_CNT > 1) ? $clog2(ISSUE_CNT) : 1;

    logic [SEL_BITS-1:0] ptr;
    logic [SEL_BITS-1:0] grant_idx;
    logic                grant_valid;
    logic                load;

    assign load = !exe_valid || exe_ready;

    // First requester at or after the pointer wins
    always_comb begin
        int unsigned idx;
        grant_valid = 1'b0;
        grant_idx   = '0;
        for (int k = 0; k < ISSUE_CNT; k++) begin
            idx = (int'(ptr) + k) % ISSUE_CNT;
            if (!grant_valid && col_valid[idx]) begin
                grant_valid = 1'b1;
                grant_idx   = SEL_BITS'(idx);
            end
        end
        for (int i = 0; i < ISSUE_CNT; i++) begin
            col_ready[i] = load && grant_valid && (int'(grant_idx) == i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
            ptr       <= '0;
        end else if (load) begin
            exe_valid <= grant_valid;
            if (grant_valid) begin
                ptr <= SEL_BITS'((int'(grant_idx) + 1) % ISSUE_CNT);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load && grant_valid) begin
            exe_data <= col_data[grant_idx];
        end
    end

endmodule

// File: verilog/operands_top.sv
// Operand collection stage: warp router, collector slices and execution arbiter
`timescale 1ns/1ps

module operands_top import operands_pkg::*; #(
    parameter int ISSUE_CNT = 2
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       flush,
    input  logic       issue_valid,
    output logic       issue_ready,
    input  issue_t     issue_data,
    input  logic       wb_valid,
    input  writeback_t wb_data,
    output logic       exe_valid,
    input  logic       exe_ready,
    output operands_t  exe_data
);

    logic [ISSUE_CNT-1:0]      slice_issue_valid;
    logic [ISSUE_CNT-1:0]      slice_ready;
    issue_t                    slice_issue_data;
    logic [ISSUE_CNT-1:0]      slice_wb_valid;
    writeback_t                slice_wb_data;
    logic [ISSUE_CNT-1:0]      col_valid;
    logic [ISSUE_CNT-1:0]      col_ready;
    operands_t [ISSUE_CNT-1:0] col_data;

    warp_router #(
        .ISSUE_CNT (ISSUE_CNT)
    ) router (
        .issue_valid       (issue_valid),
        .issue_ready       (issue_ready),
        .issue_data        (issue_data),
        .wb_valid          (wb_valid),
        .wb_data           (wb_data),
        .slice_issue_valid (slice_issue_valid),
        .slice_ready       (slice_ready),
        .slice_issue_data  (slice_issue_data),
        .slice_wb_valid    (slice_wb_valid),
        .slice_wb_data     (slice_wb_data)
    );

    for (genvar i = 0; i < ISSUE_CNT; i++) begin : g_slice
        operand_collector #(
            .ISSUE_CNT (ISSUE_CNT)
        ) collector (
            .clk         (clk),
            .reset       (reset),
            .flush       (flush),
            .issue_valid (slice_issue_valid[i]),
            .issue_ready (slice_ready[i]),
            .issue_data  (slice_issue_data),
            .wb_valid    (slice_wb_valid[i]),
            .wb_data     (slice_wb_data),
            .out_valid   (col_valid[i]),
            .out_ready   (col_ready[i]),
            .out_data    (col_data[i])
        );
    end

    // The output register also drops its item on a flush
    exec_arbiter #(
        .ISSUE_CNT (ISSUE_CNT)
    ) arbiter (
        .clk       (clk),
        .reset     (reset || flush),
        .col_valid (col_valid),
        .col_ready (col_ready),
        .col_data  (col_data),
        .exe_valid (exe_valid),
        .exe_ready (exe_ready),
        .exe_data  (exe_data)
    );

endmodule

// File: dv/operands_tb.sv
// Testbench for operands_top with shadow register model, compare tasks and watchdog
`timescale 1ns/1ps

module operands_tb import operands_pkg::*; ();

    localparam int ISSUE_CNT = 2;
    localparam int N_RAND    = 60;
    localparam int N_MIXED   = 40;
    localparam int N_FLUSHED = 4;
    localparam int N_AFTER   = 30;
    localparam int WATCHDOG_CYCLES = 60 * (N_RAND + N_MIXED + N_FLUSHED + N_AFTER) + 2000;

    logic       clk = 1'b0;
    logic       reset;
    logic       flush;
    logic       issue_valid;
    logic       issue_ready;
    issue_t     issue_data;
    logic       wb_valid;
    writeback_t wb_data;
    logic       exe_valid;
    logic       exe_ready;
    operands_t  exe_data;

    integer seed       = 87890;
    integer ready_seed = 87891;
    logic   hold_exe   = 1'b1;
    int     value_errs = 0;
    int     order_errs = 0;
    int     other_errs = 0;
    int     pending_cnt = 0;
    int     next_uuid  = 0;
    int     last_uuid [ISSUE_CNT];

    logic [XLEN-1:0] shadow [WARP_CNT][NUM_REGS][THREAD_CNT];
    operands_t       exp_mem [256];
    bit              pending [256];
    int              issue_slice [256];

    operands_top #(
        .ISSUE_CNT (ISSUE_CNT)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .flush       (flush),
        .issue_valid (issue_valid),
        .issue_ready (issue_ready),
        .issue_data  (issue_data),
        .wb_valid    (wb_valid),
        .wb_data     (wb_data),
        .exe_valid   (exe_valid),
        .exe_ready   (exe_ready),
        .exe_data    (exe_data)
    );

    always #4 clk = !clk;

    // Execution back-pressure is random unless held low
    always @(posedge clk) begin
        #1;
        exe_ready = hold_exe ? 1'b0 : (($random(ready_seed) & 3) != 0);
    end

    // Expected bundle straight from the shadow registers
    function automatic operands_t compute_operands(input issue_t ins);
        operands_t ref_ops;
        ref_ops.uuid    = ins.uuid;
        // The router hands each slice the warp's local index
        ref_ops.wid     = WID_BITS'(ins.wid / ISSUE_CNT);
        ref_ops.tmask   = ins.tmask;
        ref_ops.pc      = ins.pc;
        ref_ops.op_type = ins.op_type;
        ref_ops.use_imm = ins.use_imm;
        ref_ops.imm     = ins.imm;
        ref_ops.wb      = ins.wb;
        ref_ops.rd      = ins.rd;
        for (int j = 0; j < THREAD_CNT; j++) begin
            ref_ops.rs1_data[j] = (ins.rs1 == 0) ? '0 : shadow[ins.wid][ins.rs1][j];
            ref_ops.rs2_data[j] = (ins.rs2 == 0) ? '0 : shadow[ins.wid][ins.rs2][j];
            ref_ops.rs3_data[j] = (ins.rs3 == 0) ? '0 : shadow[ins.wid][ins.rs3][j];
        end
        return ref_ops;
    endfunction

    function automatic logic [NR_BITS-1:0] pick_reg();
        if (({$random(seed)} % 4) == 0) begin
            return '0;
        end
        return NR_BITS'({$random(seed)} % NUM_REGS);
    endfunction

    task automatic compare_field(input string name, input logic [THREAD_CNT*XLEN-1:0] got,
                                 input logic [THREAD_CNT*XLEN-1:0] exp);
        if (got !== exp) begin
            $display("** Error exe_data.%s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    task automatic check_operands(input operands_t got, input operands_t exp);
        compare_field("uuid", got.uuid, exp.uuid);
        compare_field("wid", got.wid, exp.wid);
        compare_field("tmask", got.tmask, exp.tmask);
        compare_field("pc", got.pc, exp.pc);
        compare_field("op_type", got.op_type, exp.op_type);
        compare_field("use_imm", got.use_imm, exp.use_imm);
        compare_field("imm", got.imm, exp.imm);
        compare_field("wb", got.wb, exp.wb);
        compare_field("rd", got.rd, exp.rd);
        compare_field("rs1_data", got.rs1_data, exp.rs1_data);
        compare_field("rs2_data", got.rs2_data, exp.rs2_data);
        compare_field("rs3_data", got.rs3_data, exp.rs3_data);
    endtask

    // Uuids rise with issue order, so each slice must deliver them rising
    task automatic check_order(input int slice, input logic [UUID_BITS-1:0] uuid);
        if (int'(uuid) <= last_uuid[slice]) begin
            $display("** Error exe_data.uuid in slice %0d: got %h after %h", slice, uuid,
                     last_uuid[slice]);
            order_errs++;
        end
        last_uuid[slice] = int'(uuid);
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("** Error %s: got %h, expected %h", name, got, exp);
            value_errs++;
        end
    endtask

    always @(posedge clk) begin
        if (exe_valid && exe_ready) begin
            if (!pending[exe_data.uuid]) begin
                $display("Unexpected result for uuid %h, it was never issued or was flushed",
                         exe_data.uuid);
                other_errs++;
            end else begin
                pending[exe_data.uuid] = 1'b0;
                pending_cnt--;
                check_operands(exe_data, exp_mem[exe_data.uuid]);
                check_order(issue_slice[exe_data.uuid], exe_data.uuid);
            end
        end
    end

    task automatic write_reg(input int w, input int r, input logic [THREAD_CNT-1:0] mask);
        writeback_t wbk;
        wbk.wid   = WID_BITS'(w);
        wbk.rd    = NR_BITS'(r);
        wbk.tmask = mask;
        for (int j = 0; j < THREAD_CNT; j++) begin
            wbk.data[j] = $random(seed);
            if (mask[j]) begin
                shadow[w][r][j] = wbk.data[j];
            end
        end
        wb_data  = wbk;
        wb_valid = 1'b1;
        @(posedge clk);
        #1;
        wb_valid = 1'b0;
    endtask

    task automatic issue_instr(input int w);
        issue_t ins;
        ins.uuid    = UUID_BITS'(next_uuid);
        ins.wid     = WID_BITS'(w);
        ins.tmask   = THREAD_CNT'($random(seed));
        ins.pc      = $random(seed);
        ins.op_type = op_type_e'({$random(seed)} % 11);
        ins.use_imm = 1'($random(seed));
        ins.imm     = $random(seed);
        ins.wb      = 1'($random(seed));
        ins.rd      = pick_reg();
        ins.rs1     = pick_reg();
        ins.rs2     = pick_reg();
        ins.rs3     = pick_reg();
        issue_data  = ins;
        issue_valid = 1'b1;
        exp_mem[ins.uuid] = compute_operands(ins);
        @(posedge clk);
        while (!issue_ready) begin
            @(posedge clk);
        end
        #1;
        issue_valid = 1'b0;
        issue_slice[ins.uuid] = w % ISSUE_CNT;
        pending[ins.uuid] = 1'b1;
        pending_cnt++;
        next_uuid++;
    endtask

    task automatic drain(input int max_cycles);
        int n;
        n        = 0;
        hold_exe = 1'b0;
        while (pending_cnt != 0 && n < max_cycles) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (pending_cnt != 0) begin
            $display("%0d results never came out of the execution port", pending_cnt);
            other_errs += pending_cnt;
        end
    endtask

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired with %0d results still outstanding", pending_cnt);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        reset       = 1'b1;
        flush       = 1'b0;
        issue_valid = 1'b0;
        issue_data  = '0;
        wb_valid    = 1'b0;
        wb_data     = '0;
        exe_ready   = 1'b0;
        for (int s = 0; s < ISSUE_CNT; s++) begin
            last_uuid[s] = -1;
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        @(posedge clk);
        #1;
        check_flag("exe_valid", exe_valid, 1'b0);
        check_flag("issue_ready", issue_ready, 1'b1);

        for (int w = 0; w < WARP_CNT; w++) begin
            for (int r = 1; r < NUM_REGS; r++) begin
                write_reg(w, r, '1);
            end
        end
        hold_exe = 1'b0;
        for (int i = 0; i < N_RAND; i++) begin
            issue_instr({$random(seed)} % WARP_CNT);
        end
        drain(2000);

        // Partial masks leave the disabled lanes holding their old words
        for (int i = 0; i < 40; i++) begin
            write_reg({$random(seed)} % WARP_CNT, 1 + {$random(seed)} % (NUM_REGS - 1),
                      THREAD_CNT'($random(seed)));
        end
        for (int i = 0; i < N_MIXED; i++) begin
            issue_instr({$random(seed)} % WARP_CNT);
        end
        drain(2000);

        hold_exe = 1'b1;
        @(posedge clk);
        #1;
        for (int i = 0; i < N_FLUSHED; i++) begin
            issue_instr(i);
        end
        repeat (8) @(posedge clk);
        #1;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
        for (int u = 0; u < 256; u++) begin
            if (pending[u]) begin
                pending[u] = 1'b0;
                pending_cnt--;
            end
        end
        hold_exe = 1'b0;
        for (int i = 0; i < N_AFTER; i++) begin
            issue_instr({$random(seed)} % WARP_CNT);
        end
        drain(2000);
        repeat (20) @(posedge clk);

        $display("Errors: %0d value, %0d order, %0d missing or extra", value_errs,
                 order_errs, other_errs);
        if (value_errs + order_errs + other_errs == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: src.f
verilog/operands_pkg.sv
verilog/gpr_bank.sv
verilog/elastic_buffer.sv
verilog/operand_collector.sv
verilog/warp_router.sv
verilog/exec_arbiter.sv
verilog/operands_top.sv
dv/operands_tb.sv

// File: Bender.yml
package:
  name: operands

sources:
  - files:
      - verilog/operands_pkg.sv
      - verilog/gpr_bank.sv
      - verilog/elastic_buffer.sv
      - verilog/operand_collector.sv
      - verilog/warp_router.sv
      - verilog/exec_arbiter.sv
      - verilog/operands_top.sv
  - target: test
    files:
      - dv/operands_tb.sv
